/* files.f */
isu_cfg_pkg.sv
isu_uop_pkg.sv
isu_dispatch.sv
isu_busy_table.sv
isu_rob.sv
isu_int_isq.sv
isu_top.sv
isu_properties.sv
tb_isu_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_isu_top -f files.f -o sim_isu

if ! output=$(./obj_dir/sim_isu +verilator+error+limit+100 2>&1); then
    echo "$output"
    exit 1
fi
echo "$output"
grep -qx "TESTBENCH PASSED" <<< "$output"

/* tb_isu_top.sv */
`timescale 1ns/1ns

module tb_isu_top;

    localparam logic [1:0] op_disp  = 2'd0;
    localparam logic [1:0] op_wb    = 2'd1;
    localparam logic [1:0] op_idle  = 2'd2;
    localparam logic [1:0] op_flush = 2'd3;

    // One table row: a dispatch, a writeback, idle cycles or a flush
    typedef struct packed {
        logic [1:0]          kind;
        logic                rdy;
        logic [7:0]          len;
        logic                port;
        isu_uop_pkg::robid_t robid;
        isu_uop_pkg::preg_t  prd;
        logic                mmio;
        logic                src1;
        isu_uop_pkg::preg_t  prs1;
    } step_t;

    typedef struct packed {
        isu_uop_pkg::robid_t    robid;
        isu_uop_pkg::disp_uop_t uop;
        logic                   done;
        logic                   skip;
    } rob_rec_t;

    logic                    clock = 1'b0;
    logic                    rst;
    logic                    disp_valid;
    isu_uop_pkg::disp_uop_t  disp_uop;
    logic                    disp_ready;
    isu_uop_pkg::wb_t        int_wb;
    isu_uop_pkg::wb_t        mem_wb;
    logic                    flush;
    logic                    issue_valid;
    logic                    issue_ready;
    isu_uop_pkg::issue_uop_t issue_uop;
    isu_uop_pkg::commit_t    commit;

    step_t                   steps [$];
    isu_uop_pkg::issue_uop_t q_uop [$];
    logic                    q_r1 [$];
    logic                    q_r2 [$];
    rob_rec_t                rob_q [$];
    logic [isu_cfg_pkg::preg_num-1:0] bsy = '0;
    isu_uop_pkg::robid_t     disp_robid = '0;
    logic [31:0]             lfsr_state = 32'h7b90108b;
    int                      checks = 0;
    int                      errors = 0;
    int                      cycles = 0;
    int                      cycle_limit = 1000000;

    isu_top dut_i (
        .clock       (clock      ),
        .rst         (rst        ),
        .disp_valid  (disp_valid ),
        .disp_uop    (disp_uop   ),
        .disp_ready  (disp_ready ),
        .int_wb      (int_wb     ),
        .mem_wb      (mem_wb     ),
        .flush       (flush      ),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop  ),
        .commit      (commit     )
    );

    bind isu_top isu_properties props_i (
        .clock       (clock      ),
        .rst         (rst        ),
        .flush       (flush      ),
        .disp_ready  (disp_ready ),
        .issue_valid (issue_valid),
        .commit      (commit     )
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: table not finished after %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bcd35c) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic step_t table_row(input logic [1:0] kind, input int rdy, input int len,
                                        input int port, input int robid, input int prd,
                                        input int mmio, input int src1, input int prs1);
        step_t s;
        s.kind  = kind;
        s.rdy   = 1'(rdy);
        s.len   = 8'(len);
        s.port  = 1'(port);
        s.robid = isu_uop_pkg::robid_t'(robid);
        s.prd   = isu_uop_pkg::preg_t'(prd);
        s.mmio  = 1'(mmio);
        s.src1  = 1'(src1);
        s.prs1  = isu_uop_pkg::preg_t'(prs1);
        return s;
    endfunction

    // Payload fields the unit only carries come from the LFSR
    function automatic isu_uop_pkg::disp_uop_t random_uop(input step_t s);
        isu_uop_pkg::disp_uop_t u;
        u.pc          = take_bits(32);
        u.instr       = take_bits(32);
        u.lrs1        = isu_uop_pkg::lreg_t'(take_bits(5));
        u.lrs2        = isu_uop_pkg::lreg_t'(take_bits(5));
        u.lrd         = isu_uop_pkg::lreg_t'(take_bits(5));
        u.prd         = s.prd;
        u.old_prd     = isu_uop_pkg::preg_t'(take_bits(6));
        u.need_to_wb  = 1'b1;
        u.prs1        = s.prs1;
        u.prs2        = '0;
        u.src1_is_reg = s.src1;
        u.src2_is_reg = 1'b0;
        u.imm         = take_bits(32);
        u.alu_type    = 11'(take_bits(11));
        u.is_load     = 1'(take_bits(1));
        u.is_store    = 1'(take_bits(1));
        return u;
    endfunction

    task automatic build_table();
        // Independent ops, then writebacks out of order with one MMIO
        steps.push_back(table_row(op_disp, 1, 0, 0, 0, 10, 0, 0, 0));
        steps.push_back(table_row(op_disp, 1, 0, 0, 1, 11, 0, 0, 0));
        steps.push_back(table_row(op_disp, 1, 0, 0, 2, 12, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 3, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 0, 2, 12, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 0, 0, 10, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 1, 1, 11, 1, 0, 0));
        steps.push_back(table_row(op_idle, 1, 4, 0, 0, 0, 0, 0, 0));
        // Consumer of p20 waits while a younger op issues
        steps.push_back(table_row(op_disp, 1, 0, 0, 3, 20, 0, 0, 0));
        steps.push_back(table_row(op_disp, 1, 0, 0, 4, 21, 0, 1, 20));
        steps.push_back(table_row(op_disp, 1, 0, 0, 5, 22, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 3, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 0, 3, 20, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 2, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 0, 4, 21, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 1, 5, 22, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 4, 0, 0, 0, 0, 0, 0));
        // Fill the queue with execute stalled
        for (int i = 0; i < 8; i++) begin
            steps.push_back(table_row(op_disp, 0, 0, 0, 6 + i, 30 + i, 0, 0, 0));
        end
        steps.push_back(table_row(op_idle, 0, 3, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_disp, 1, 0, 0, 14, 38, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 3, 0, 0, 0, 0, 0, 0));
        for (int i = 0; i < 9; i++) begin
            steps.push_back(table_row(op_wb, 1, 0, i % 2, 6 + i, 30 + i, 0, 0, 0));
        end
        steps.push_back(table_row(op_idle, 1, 4, 0, 0, 0, 0, 0, 0));
        // Flush with a completed head and p41 still busy, robid wraps to 16 before it
        steps.push_back(table_row(op_disp, 0, 0, 0, 15, 40, 0, 0, 0));
        steps.push_back(table_row(op_disp, 0, 0, 0, 16, 41, 0, 1, 40));
        steps.push_back(table_row(op_wb, 0, 0, 0, 15, 40, 0, 0, 0));
        steps.push_back(table_row(op_flush, 0, 0, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 2, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_disp, 1, 0, 0, 0, 42, 0, 1, 41));
        steps.push_back(table_row(op_idle, 1, 2, 0, 0, 0, 0, 0, 0));
        steps.push_back(table_row(op_wb, 1, 0, 0, 0, 42, 0, 0, 0));
        steps.push_back(table_row(op_idle, 1, 3, 0, 0, 0, 0, 0, 0));
    endtask

    task automatic drive_row(input step_t s, input isu_uop_pkg::disp_uop_t u);
        isu_uop_pkg::wb_t w;
        isu_uop_pkg::wb_t none;
        none         = '0;
        w.valid      = (s.kind == op_wb);
        w.robid      = s.robid;
        w.prd        = s.prd;
        w.need_to_wb = 1'b1;
        w.mmio       = s.mmio;
        if (s.kind == op_disp) begin
            disp_robid = s.robid;
        end
        disp_valid  <= (s.kind == op_disp);
        disp_uop    <= u;
        int_wb      <= s.port ? none : w;
        mem_wb      <= s.port ? w : none;
        flush       <= (s.kind == op_flush);
        issue_ready <= s.rdy;
    endtask

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("At %0t ns: %s", $time, what);
        end
    endtask

    function automatic logic tag_written(input isu_uop_pkg::preg_t tag);
        return (int_wb.valid && int_wb.need_to_wb && int_wb.prd == tag) ||
               (mem_wb.valid && mem_wb.need_to_wb && mem_wb.prd == tag);
    endfunction

    // Compare this cycle's outputs, then advance the model past the next edge
    task automatic model_cycle();
        isu_uop_pkg::issue_uop_t iu;
        isu_uop_pkg::commit_t    exp_c;
        rob_rec_t                rec;
        logic                    exp_ready;
        int                      sel;
        exp_ready = (rob_q.size() < isu_cfg_pkg::rob_depth) &&
                    (q_uop.size() < isu_cfg_pkg::isq_depth) && !flush;
        sel = -1;
        for (int i = q_uop.size() - 1; i >= 0; i--) begin
            if (q_r1[i] && q_r2[i]) begin
                sel = i;
            end
        end
        exp_c = '0;
        if (rob_q.size() > 0) begin
            rec                = rob_q[0];
            exp_c.valid        = rec.done && !flush;
            exp_c.robid        = rec.robid;
            exp_c.pc           = rec.uop.pc;
            exp_c.instr        = rec.uop.instr;
            exp_c.lrd          = rec.uop.lrd;
            exp_c.prd          = rec.uop.prd;
            exp_c.old_prd      = rec.uop.old_prd;
            exp_c.need_to_wb   = rec.uop.need_to_wb;
            exp_c.skip         = rec.skip;
        end
        check_value("disp_ready", 160'(disp_ready), 160'(exp_ready));
        check_value("issue_valid", 160'(issue_valid), 160'(sel >= 0));
        if (sel >= 0) begin
            check_value("issue_uop", 160'(issue_uop), 160'(q_uop[sel]));
        end
        if (exp_c.valid) begin
            check_value("commit", 160'(commit), 160'(exp_c));
        end else begin
            check_value("commit.valid", 160'(commit.valid), 160'(1'b0));
        end
        if (flush) begin
            q_uop.delete();
            q_r1.delete();
            q_r2.delete();
            rob_q.delete();
            bsy = '0;
        end else begin
            for (int i = 0; i < q_uop.size(); i++) begin
                q_r1[i] = q_r1[i] || tag_written(q_uop[i].uop.prs1);
                q_r2[i] = q_r2[i] || tag_written(q_uop[i].uop.prs2);
            end
            if (sel >= 0 && issue_ready) begin
                q_uop.delete(sel);
                q_r1.delete(sel);
                q_r2.delete(sel);
            end
            for (int i = 0; i < rob_q.size(); i++) begin
                rec = rob_q[i];
                if (int_wb.valid && int_wb.robid == rec.robid) begin
                    rec.done = 1'b1;
                end
                if (mem_wb.valid && mem_wb.robid == rec.robid) begin
                    rec.done = 1'b1;
                    rec.skip = rec.skip | mem_wb.mmio;
                end
                rob_q[i] = rec;
            end
            if (exp_c.valid) begin
                void'(rob_q.pop_front());
            end
            if (int_wb.valid && int_wb.need_to_wb) begin
                bsy[int_wb.prd] = 1'b0;
            end
            if (mem_wb.valid && mem_wb.need_to_wb) begin
                bsy[mem_wb.prd] = 1'b0;
            end
            if (disp_valid && exp_ready) begin
                iu.robid = disp_robid;
                iu.uop   = disp_uop;
                q_uop.push_back(iu);
                q_r1.push_back(!disp_uop.src1_is_reg || !bsy[disp_uop.prs1] ||
                               tag_written(disp_uop.prs1));
                q_r2.push_back(!disp_uop.src2_is_reg || !bsy[disp_uop.prs2] ||
                               tag_written(disp_uop.prs2));
                rec.robid = disp_robid;
                rec.uop   = disp_uop;
                rec.done  = 1'b0;
                rec.skip  = 1'b0;
                rob_q.push_back(rec);
                if (disp_uop.need_to_wb) begin
                    bsy[disp_uop.prd] = 1'b1;
                end
            end
        end
    endtask

    always @(negedge clock) begin
        if (!rst) begin
            model_cycle();
        end
    end

    initial begin
        step_t                  s;
        isu_uop_pkg::disp_uop_t u;
        logic                   accepted;
        rst         = 1'b1;
        disp_valid  = 1'b0;
        disp_uop    = '0;
        int_wb      = '0;
        mem_wb      = '0;
        flush       = 1'b0;
        issue_ready = 1'b0;
        build_table();
        cycle_limit = 20 * steps.size() + 200;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        foreach (steps[k]) begin
            s = steps[k];
            u = '0;
            if (s.kind == op_disp) begin
                u = random_uop(s);
            end
            drive_row(s, u);
            if (s.kind == op_disp) begin
                accepted = 1'b0;
                while (!accepted) begin
                    @(negedge clock);
                    accepted = disp_ready;
                    @(posedge clock);
                end
            end else if (s.kind == op_idle) begin
                repeat (s.len) @(posedge clock);
            end else begin
                @(posedge clock);
            end
        end
        check_true(rob_q.size() == 0 && q_uop.size() == 0, "work left over after the last row");
        $display("%0d checks, %0d errors, %0d property failures",
                 checks, errors, dut_i.props_i.fails);
        if (errors == 0 && dut_i.props_i.fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* isu_properties.sv */
`timescale 1ns/1ns

module isu_properties (
    input logic                 clock,
    input logic                 rst,
    input logic                 flush,
    input logic                 disp_ready,
    input logic                 issue_valid,
    input isu_uop_pkg::commit_t commit
);

    // Property failures seen so far
    int fails = 0;

    no_dispatch_in_flush: assert property (
        @(posedge clock) disable iff (rst) flush |-> !disp_ready
    ) else begin
        fails++;
        $error("disp_ready high in a flush cycle");
    end

    // Queue is empty once the flush edge has passed
    no_issue_after_flush: assert property (
        @(posedge clock) disable iff (rst) flush |=> !issue_valid
    ) else begin
        fails++;
        $error("issue_valid high in the cycle after a flush");
    end

    no_commit_in_flush: assert property (
        @(posedge clock) disable iff (rst) flush |-> !commit.valid
    ) else begin
        fails++;
        $error("commit.valid high in a flush cycle");
    end

endmodule

/* isu_top.sv */
`timescale 1ns/1ns

module isu_top (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    disp_valid,
    input  isu_uop_pkg::disp_uop_t  disp_uop,
    output logic                    disp_ready,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush,
    output logic                    issue_valid,
    input  logic                    issue_ready,
    output isu_uop_pkg::issue_uop_t issue_uop,
    output isu_uop_pkg::commit_t    commit
);

    logic                    rob_can_enq;
    logic                    isq_can_enq;
    isu_uop_pkg::robid_t     alloc_robid;
    logic                    enq;
    isu_uop_pkg::preg_t      rs1_tag;
    isu_uop_pkg::preg_t      rs2_tag;
    logic                    rs1_busy;
    logic                    rs2_busy;
    logic                    alloc_en;
    isu_uop_pkg::preg_t      alloc_prd;
    isu_uop_pkg::issue_uop_t isq_uop;
    logic                    src1_rdy;
    logic                    src2_rdy;
    isu_uop_pkg::rob_entry_t rob_entry;

    // Commit fields taken from the incoming micro-op
    assign rob_entry = '{
        pc:         disp_uop.pc,
        instr:      disp_uop.instr,
        lrd:        disp_uop.lrd,
        prd:        disp_uop.prd,
        old_prd:    disp_uop.old_prd,
        need_to_wb: disp_uop.need_to_wb,
        skip:       1'b0
    };

    isu_dispatch u_dispatch (
        .disp_valid  (disp_valid ),
        .disp_uop    (disp_uop   ),
        .disp_ready  (disp_ready ),
        .rob_can_enq (rob_can_enq),
        .isq_can_enq (isq_can_enq),
        .alloc_robid (alloc_robid),
        .flush       (flush      ),
        .int_wb      (int_wb     ),
        .mem_wb      (mem_wb     ),
        .rs1_tag     (rs1_tag    ),
        .rs2_tag     (rs2_tag    ),
        .rs1_busy    (rs1_busy   ),
        .rs2_busy    (rs2_busy   ),
        .enq         (enq        ),
        .alloc_en    (alloc_en   ),
        .alloc_prd   (alloc_prd  ),
        .isq_uop     (isq_uop    ),
        .src1_rdy    (src1_rdy   ),
        .src2_rdy    (src2_rdy   )
    );

    isu_busy_table u_busy_table (
        .clock     (clock    ),
        .rst       (rst      ),
        .rs1_tag   (rs1_tag  ),
        .rs2_tag   (rs2_tag  ),
        .rs1_busy  (rs1_busy ),
        .rs2_busy  (rs2_busy ),
        .alloc_en  (alloc_en ),
        .alloc_prd (alloc_prd),
        .int_wb    (int_wb   ),
        .mem_wb    (mem_wb   ),
        .flush     (flush    )
    );

    isu_rob u_rob (
        .clock       (clock      ),
        .rst         (rst        ),
        .enq         (enq        ),
        .enq_entry   (rob_entry  ),
        .alloc_robid (alloc_robid),
        .rob_can_enq (rob_can_enq),
        .int_wb      (int_wb     ),
        .mem_wb      (mem_wb     ),
        .flush       (flush      ),
        .commit      (commit     )
    );

    isu_int_isq u_int_isq (
        .clock       (clock      ),
        .rst         (rst        ),
        .enq         (enq        ),
        .enq_uop     (isq_uop    ),
        .src1_rdy    (src1_rdy   ),
        .src2_rdy    (src2_rdy   ),
        .isq_can_enq (isq_can_enq),
        .int_wb      (int_wb     ),
        .mem_wb      (mem_wb     ),
        .flush       (flush      ),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop  )
    );

endmodule

/* isu_int_isq.sv */
`timescale 1ns/1ns

module isu_int_isq (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    enq,
    input  isu_uop_pkg::issue_uop_t enq_uop,
    input  logic                    src1_rdy,
    input  logic                    src2_rdy,
    output logic                    isq_can_enq,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush,
    output logic                    issue_valid,
    input  logic                    issue_ready,
    output isu_uop_pkg::issue_uop_t issue_uop
);

    // Slot 0 holds the oldest entry
    isu_uop_pkg::issue_uop_t uops   [isu_cfg_pkg::isq_depth];
    isu_uop_pkg::issue_uop_t c_uops [isu_cfg_pkg::isq_depth];

    logic [isu_cfg_pkg::isq_depth-1:0] vld;
    logic [isu_cfg_pkg::isq_depth-1:0] rdy1;
    logic [isu_cfg_pkg::isq_depth-1:0] rdy2;
    logic [isu_cfg_pkg::isq_depth-1:0] w_rdy1;
    logic [isu_cfg_pkg::isq_depth-1:0] w_rdy2;
    logic [isu_cfg_pkg::isq_depth-1:0] c_vld;
    logic [isu_cfg_pkg::isq_depth-1:0] c_rdy1;
    logic [isu_cfg_pkg::isq_depth-1:0] c_rdy2;
    logic [isu_cfg_pkg::isq_depth-1:0] req;
    logic [isu_cfg_pkg::isq_depth-1:0] sel_oh;
    logic [isu_cfg_pkg::isq_depth-1:0] shift_mask;
    logic [isu_cfg_pkg::isq_depth-1:0] free;
    logic [isu_cfg_pkg::isq_depth-1:0] enq_oh;
    logic                              fire;

    // Entries stay contiguous, so the top slot tells fullness
    assign isq_can_enq = !vld[isu_cfg_pkg::isq_depth-1];

    // Oldest entry with both sources ready
    assign req         = vld & rdy1 & rdy2;
    assign sel_oh      = req & (~req + 1'b1);
    assign issue_valid = |req;
    assign fire        = issue_valid && issue_ready;

    always_comb begin
        issue_uop = '0;
        for (int i = isu_cfg_pkg::isq_depth - 1; i >= 0; i--) begin
            if (req[i]) begin
                issue_uop = uops[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < isu_cfg_pkg::isq_depth; i++) begin
            w_rdy1[i] = rdy1[i] || isu_uop_pkg::wb_frees(uops[i].uop.prs1, int_wb, mem_wb);
            w_rdy2[i] = rdy2[i] || isu_uop_pkg::wb_frees(uops[i].uop.prs2, int_wb, mem_wb);
        end
    end

    // Slots at and above the issued one move down by one
    assign shift_mask = fire ? ~(sel_oh - 1'b1) : '0;

    always_comb begin
        for (int i = 0; i < isu_cfg_pkg::isq_depth - 1; i++) begin
            if (shift_mask[i]) begin
                c_vld[i]  = vld[i+1];
                c_rdy1[i] = w_rdy1[i+1];
                c_rdy2[i] = w_rdy2[i+1];
                c_uops[i] = uops[i+1];
            end else begin
                c_vld[i]  = vld[i];
                c_rdy1[i] = w_rdy1[i];
                c_rdy2[i] = w_rdy2[i];
                c_uops[i] = uops[i];
            end
        end
        c_vld[isu_cfg_pkg::isq_depth-1] = vld[isu_cfg_pkg::isq_depth-1] &&
                                          !shift_mask[isu_cfg_pkg::isq_depth-1];
        c_rdy1[isu_cfg_pkg::isq_depth-1] = w_rdy1[isu_cfg_pkg::isq_depth-1];
        c_rdy2[isu_cfg_pkg::isq_depth-1] = w_rdy2[isu_cfg_pkg::isq_depth-1];
        c_uops[isu_cfg_pkg::isq_depth-1] = uops[isu_cfg_pkg::isq_depth-1];
    end

    // New entry lands in the first free slot after the collapse
    assign free   = ~c_vld;
    assign enq_oh = {isu_cfg_pkg::isq_depth{enq}} & free & (~free + 1'b1);

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            vld  <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            vld  <= c_vld | enq_oh;
            rdy1 <= (c_rdy1 & ~enq_oh) | ({isu_cfg_pkg::isq_depth{src1_rdy}} & enq_oh);
            rdy2 <= (c_rdy2 & ~enq_oh) | ({isu_cfg_pkg::isq_depth{src2_rdy}} & enq_oh);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < isu_cfg_pkg::isq_depth; i++) begin
            if (enq_oh[i]) begin
                uops[i] <= enq_uop;
            end else begin
                uops[i] <= c_uops[i];
            end
        end
    end

endmodule

/* isu_rob.sv */
`timescale 1ns/1ns

module isu_rob (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    enq,
    input  isu_uop_pkg::rob_entry_t enq_entry,
    output isu_uop_pkg::robid_t     alloc_robid,
    output logic                    rob_can_enq,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    input  logic                    flush,
    output isu_uop_pkg::commit_t    commit
);

    isu_uop_pkg::rob_entry_t entries [isu_cfg_pkg::rob_depth];

    logic [isu_cfg_pkg::rob_depth-1:0]  valid;
    logic [isu_cfg_pkg::rob_depth-1:0]  complete;
    isu_uop_pkg::robid_t                head;
    isu_uop_pkg::robid_t                tail;
    logic [isu_cfg_pkg::rob_idx_w-1:0]  head_idx;
    logic [isu_cfg_pkg::rob_idx_w-1:0]  tail_idx;
    logic [isu_cfg_pkg::rob_idx_w-1:0]  int_idx;
    logic [isu_cfg_pkg::rob_idx_w-1:0]  mem_idx;
    logic                               full;

    assign head_idx = head[isu_cfg_pkg::rob_idx_w-1:0];
    assign tail_idx = tail[isu_cfg_pkg::rob_idx_w-1:0];
    assign int_idx  = int_wb.robid[isu_cfg_pkg::rob_idx_w-1:0];
    assign mem_idx  = mem_wb.robid[isu_cfg_pkg::rob_idx_w-1:0];

    // Same index with opposite wrap bits means full
    assign full = (head_idx == tail_idx) &&
                  (head[isu_cfg_pkg::robid_w-1] != tail[isu_cfg_pkg::robid_w-1]);

    assign rob_can_enq = !full;
    assign alloc_robid = tail;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            head     <= '0;
            tail     <= '0;
            valid    <= '0;
            complete <= '0;
        end else begin
            if (enq) begin
                valid[tail_idx]    <= 1'b1;
                complete[tail_idx] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            if (int_wb.valid) begin
                complete[int_idx] <= 1'b1;
            end
            if (mem_wb.valid) begin
                complete[mem_idx] <= 1'b1;
            end
            if (commit.valid) begin
                valid[head_idx] <= 1'b0;
                head            <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            entries[tail_idx] <= enq_entry;
        end
        // MMIO access is not replayed at commit
        if (mem_wb.valid && mem_wb.mmio) begin
            entries[mem_idx].skip <= 1'b1;
        end
    end

    always_comb begin
        commit.valid      = valid[head_idx] && complete[head_idx] && !flush;
        commit.robid      = head;
        commit.pc         = entries[head_idx].pc;
        commit.instr      = entries[head_idx].instr;
        commit.lrd        = entries[head_idx].lrd;
        commit.prd        = entries[head_idx].prd;
        commit.old_prd    = entries[head_idx].old_prd;
        commit.need_to_wb = entries[head_idx].need_to_wb;
        commit.skip       = entries[head_idx].skip;
    end

endmodule

/* isu_busy_table.sv */
`timescale 1ns/1ns

module isu_busy_table (
    input  logic               clock,
    input  logic               rst,
    input  isu_uop_pkg::preg_t rs1_tag,
    input  isu_uop_pkg::preg_t rs2_tag,
    output logic               rs1_busy,
    output logic               rs2_busy,
    input  logic               alloc_en,
    input  isu_uop_pkg::preg_t alloc_prd,
    input  isu_uop_pkg::wb_t   int_wb,
    input  isu_uop_pkg::wb_t   mem_wb,
    input  logic               flush
);

    logic [isu_cfg_pkg::preg_num-1:0] busy;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (int_wb.valid && int_wb.need_to_wb) begin
                busy[int_wb.prd] <= 1'b0;
            end
            if (mem_wb.valid && mem_wb.need_to_wb) begin
                busy[mem_wb.prd] <= 1'b0;
            end
            // New allocation wins over a clear of the same tag
            if (alloc_en) begin
                busy[alloc_prd] <= 1'b1;
            end
        end
    end

    assign rs1_busy = busy[rs1_tag];
    assign rs2_busy = busy[rs2_tag];

endmodule

/* isu_dispatch.sv */
`timescale 1ns/1ns

module isu_dispatch (
    input  logic                    disp_valid,
    input  isu_uop_pkg::disp_uop_t  disp_uop,
    output logic                    disp_ready,
    input  logic                    rob_can_enq,
    input  logic                    isq_can_enq,
    input  isu_uop_pkg::robid_t     alloc_robid,
    input  logic                    flush,
    input  isu_uop_pkg::wb_t        int_wb,
    input  isu_uop_pkg::wb_t        mem_wb,
    output isu_uop_pkg::preg_t      rs1_tag,
    output isu_uop_pkg::preg_t      rs2_tag,
    input  logic                    rs1_busy,
    input  logic                    rs2_busy,
    output logic                    enq,
    output logic                    alloc_en,
    output isu_uop_pkg::preg_t      alloc_prd,
    output isu_uop_pkg::issue_uop_t isq_uop,
    output logic                    src1_rdy,
    output logic                    src2_rdy
);

    logic rs1_freed;
    logic rs2_freed;

    // Both the reorder buffer and the queue must have room
    assign disp_ready = rob_can_enq && isq_can_enq && !flush;
    assign enq        = disp_valid && disp_ready;

    assign rs1_tag = disp_uop.prs1;
    assign rs2_tag = disp_uop.prs2;

    // Writeback in this cycle overrides a stale busy bit
    assign rs1_freed = isu_uop_pkg::wb_frees(disp_uop.prs1, int_wb, mem_wb);
    assign rs2_freed = isu_uop_pkg::wb_frees(disp_uop.prs2, int_wb, mem_wb);

    assign src1_rdy = !disp_uop.src1_is_reg || !rs1_busy || rs1_freed;
    assign src2_rdy = !disp_uop.src2_is_reg || !rs2_busy || rs2_freed;

    // Destination becomes busy until its writeback
    assign alloc_en  = enq && disp_uop.need_to_wb;
    assign alloc_prd = disp_uop.prd;

    assign isq_uop.robid = alloc_robid;
    assign isq_uop.uop   = disp_uop;

endmodule

/* isu_uop_pkg.sv */
package isu_uop_pkg;

    typedef logic [isu_cfg_pkg::preg_w-1:0]  preg_t;
    typedef logic [isu_cfg_pkg::lreg_w-1:0]  lreg_t;
    typedef logic [isu_cfg_pkg::robid_w-1:0] robid_t;

    // Renamed micro-op as delivered by rename
    typedef struct packed {
        logic [isu_cfg_pkg::pc_w-1:0]       pc;
        logic [31:0]                        instr;
        lreg_t                              lrs1;
        lreg_t                              lrs2;
        lreg_t                              lrd;
        preg_t                              prd;
        preg_t                              old_prd;
        logic                               need_to_wb;
        preg_t                              prs1;
        preg_t                              prs2;
        logic                               src1_is_reg;
        logic                               src2_is_reg;
        logic [isu_cfg_pkg::imm_w-1:0]      imm;
        logic [isu_cfg_pkg::alu_type_w-1:0] alu_type;
        logic                               is_load;
        logic                               is_store;
    } disp_uop_t;

    typedef struct packed {
        robid_t    robid;
        disp_uop_t uop;
    } issue_uop_t;

    typedef struct packed {
        logic   valid;
        robid_t robid;
        preg_t  prd;
        logic   need_to_wb;
        logic   mmio;
    } wb_t;

    // Fields the reorder buffer keeps until retirement
    typedef struct packed {
        logic [isu_cfg_pkg::pc_w-1:0] pc;
        logic [31:0]                  instr;
        lreg_t                        lrd;
        preg_t                        prd;
        preg_t                        old_prd;
        logic                         need_to_wb;
        logic                         skip;
    } rob_entry_t;

    typedef struct packed {
        logic                         valid;
        robid_t                       robid;
        logic [isu_cfg_pkg::pc_w-1:0] pc;
        logic [31:0]                  instr;
        lreg_t                        lrd;
        preg_t                        prd;
        preg_t                        old_prd;
        logic                         need_to_wb;
        logic                         skip;
    } commit_t;

    // True when either writeback port produces this tag this cycle
    function automatic logic wb_frees(input preg_t tag, input wb_t a, input wb_t b);
        logic hit_a;
        logic hit_b;
        hit_a = a.valid && a.need_to_wb && (a.prd == tag);
        hit_b = b.valid && b.need_to_wb && (b.prd == tag);
        return hit_a || hit_b;
    endfunction

endpackage

/* isu_cfg_pkg.sv */
package isu_cfg_pkg;

    // Physical and logical register tags
    localparam int preg_w   = 6;
    localparam int preg_num = 64;
    localparam int lreg_w   = 5;

    // Reorder buffer, robid carries one wrap bit above the index
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;
    localparam int robid_w   = 5;

    // Integer issue queue
    localparam int isq_depth = 8;

    // Micro-op payload widths
    localparam int pc_w       = 32;
    localparam int imm_w      = 32;
    localparam int alu_type_w = 11;

endpackage
